//--- project.f
+incdir+src
src/glb_cfg_pkg.sv
src/glb_dma_pkg.sv
src/cfg_ifc.sv
src/dma_hdr_ifc.sv
src/glb_apb_bridge.sv
src/glb_tile_cfg.sv
src/glb_store_sched.sv
src/glb_top.sv
tb/glb_asserts.sv
tb/tb_glb_top.sv

//--- Makefile
# Verilator build and run of the global buffer configuration testbench.

SRCS := $(shell grep -v '^+' project.f) src/glb_defs.svh

obj_dir/Vtb_glb_top: project.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_glb_top -f project.f -o Vtb_glb_top

.PHONY: run clean

# the run passes only if the pass line shows up in the simulator output.
run: obj_dir/Vtb_glb_top
	@out="$$(./obj_dir/Vtb_glb_top +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- tb/tb_glb_top.sv
/*
 * Testbench for the global buffer configuration slice.
 * Applies a table of APB accesses and job checks; a register model and
 * a round-robin model supply the expected values.
 */
`timescale 1ns/100ps
`default_nettype none

`include "glb_defs.svh"

module tb_glb_top;

    localparam int NT          = `NUM_TILES;
    localparam int QD          = `QUEUE_DEPTH;
    localparam int MAX_ENTRIES = 256;
    localparam int APB_TIMEOUT = `CFG_RD_TIMEOUT + 16;
    localparam int JOB_TIMEOUT = 200;

    typedef enum logic [2:0] {K_WR, K_RD, K_RD_ERR, K_JOB, K_IDLE} kind_e;

    logic                            clk;
    logic                            reset;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [`CFG_ADDR_WIDTH-1:0]      paddr;
    logic [`CFG_DATA_WIDTH-1:0]      pwdata;
    logic [`CFG_DATA_WIDTH-1:0]      prdata;
    logic                            pready;
    logic                            pslverr;
    logic                            job_valid;
    logic                            job_ready;
    logic [`TILE_ID_WIDTH-1:0]       job_tile;
    logic [`GLB_ADDR_WIDTH-1:0]      job_addr;
    logic [`MAX_NUM_WORDS_WIDTH-1:0] job_words;

    // stimulus table with one access or job check per entry.
    kind_e                      tbl_kind [MAX_ENTRIES];
    logic [`CFG_ADDR_WIDTH-1:0] tbl_addr [MAX_ENTRIES];
    logic [31:0]                tbl_data [MAX_ENTRIES];
    logic [31:0]                tbl_exp  [MAX_ENTRIES];
    int                         n_entries;

    // register model.
    logic                            m_on    [NT];
    logic                            m_valid [NT][QD];
    logic [`GLB_ADDR_WIDTH-1:0]      m_addr  [NT][QD];
    logic [`MAX_NUM_WORDS_WIDTH-1:0] m_words [NT][QD];
    int                              m_ptr;      // next tile the scheduler looks at.
    integer                          seed;

    glb_top u_glb_top (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .job_tile  (job_tile),
        .job_addr  (job_addr),
        .job_words (job_words)
    );

    bind glb_top glb_asserts u_asserts (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pready    (pready),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .job_tile  (job_tile),
        .job_addr  (job_addr),
        .job_words (job_words),
        .inval     ({hdr_link[3].invalidate_pulse, hdr_link[2].invalidate_pulse,
                     hdr_link[1].invalidate_pulse, hdr_link[0].invalidate_pulse})
    );

    always #10 clk = ~clk;

    //======================================================================
    // reporting
    //======================================================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0d ns: %s got %h, expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    always @(negedge clk) begin
        if (!reset && u_glb_top.u_asserts.fail_cnt != 0) begin
            abort_run("a bound assertion on the DUT handshakes failed");
        end
    end

    //======================================================================
    // register map and scheduling model
    //======================================================================
    function automatic logic [`CFG_ADDR_WIDTH-1:0] cfg_addr(input int t, input int off);
        logic [`CFG_ADDR_WIDTH-1:0] a;
        a = '0;
        a[`CFG_TILE_LSB +: `CFG_TILE_WIDTH] = t[`CFG_TILE_WIDTH-1:0];
        a[`CFG_REG_LSB +: `CFG_REG_WIDTH]   = off[`CFG_REG_WIDTH-1:0];
        return a;
    endfunction

    function automatic logic [31:0] model_read(input int t, input int off);
        int q;
        q = (off - 1) / 2;
        if (off == 0) return {31'b0, m_on[t]};
        if (off > 2 * QD) return '0;   // past the queue.
        if (off % 2 == 1) return 32'(m_words[t][q]);
        return 32'({m_addr[t][q], m_valid[t][q]});
    endfunction

    task automatic push_entry(input kind_e k, input logic [`CFG_ADDR_WIDTH-1:0] a,
                              input logic [31:0] d, input logic [31:0] e);
        tbl_kind[n_entries] = k;
        tbl_addr[n_entries] = a;
        tbl_data[n_entries] = d;
        tbl_exp[n_entries]  = e;
        n_entries++;
    endtask

    task automatic add_write(input int t, input int off, input logic [31:0] d);
        int q;
        q = (off - 1) / 2;
        if (off == 0) begin
            m_on[t] = d[0];
        end else if (off <= 2 * QD && off % 2 == 1) begin
            m_words[t][q] = d[`MAX_NUM_WORDS_WIDTH-1:0];
        end else if (off <= 2 * QD) begin
            m_valid[t][q] = d[0];
            m_addr[t][q]  = d[`GLB_ADDR_WIDTH:1];
        end
        push_entry(K_WR, cfg_addr(t, off), d, '0);
    endtask

    task automatic add_read(input int t, input int off);
        if (t < NT) push_entry(K_RD, cfg_addr(t, off), '0, model_read(t, off));
        else push_entry(K_RD_ERR, cfg_addr(t, off), '0, '0);   // nobody answers.
    endtask

    task automatic arm_header(input int t, input int q);
        logic [31:0] r;
        r = $random(seed);
        add_write(t, 2 + 2 * q, r | 32'h1);
    endtask

    // next job by round-robin over enabled tiles with the lowest valid index first.
    task automatic add_job(input logic random_ready);
        int t;
        int pick_t;
        int pick_q;
        pick_t = -1;
        pick_q = -1;
        for (int i = 0; i < NT; i++) begin
            t = (m_ptr + i) % NT;
            if (pick_t < 0 && m_on[t]) begin
                for (int q = QD - 1; q >= 0; q--) begin
                    if (m_valid[t][q]) pick_q = q;
                end
                if (pick_q >= 0) pick_t = t;
            end
        end
        if (pick_t < 0) abort_run("stimulus table expects a job that cannot exist");
        push_entry(K_JOB, '0, {31'b0, random_ready},
                   {2'b00, pick_t[`TILE_ID_WIDTH-1:0], m_addr[pick_t][pick_q],
                    m_words[pick_t][pick_q]});
        m_valid[pick_t][pick_q] = 1'b0;
        m_ptr = (pick_t + 1) % NT;
    endtask

    task automatic add_round(input logic random_ready);
        for (int t = 0; t < 3; t++) add_write(t, 0, 32'h0);
        arm_header(0, 3);
        arm_header(0, 1);
        arm_header(1, 0);
        arm_header(2, 2);
        arm_header(2, 0);
        arm_header(3, 1);   // tile 3 stays off.
        arm_header(3, 0);
        for (int t = 0; t < 3; t++) add_write(t, 0, 32'h1);
        m_ptr = 0;   // tile 0 is on alone for a full sweep and is caught first.
        repeat (5) add_job(random_ready);
        push_entry(K_IDLE, '0, 32'd20, '0);
        add_read(0, 4);
        add_read(0, 8);
        add_read(1, 2);
        add_read(2, 2);
        add_read(2, 6);
        add_read(3, 2);
        add_read(3, 4);
    endtask

    task automatic build_table();
        logic [31:0] r;
        n_entries = 0;
        m_ptr     = 0;
        for (int t = 0; t < NT; t++) begin
            m_on[t] = 1'b0;
            for (int q = 0; q < QD; q++) begin
                m_valid[t][q] = 1'b0;
                m_addr[t][q]  = '0;
                m_words[t][q] = '0;
            end
        end
        // read-back of every register with the headers left invalid.
        for (int t = 0; t < NT; t++) begin
            for (int q = 0; q < QD; q++) begin
                r = $random(seed);
                add_write(t, 1 + 2 * q, r);
                r = $random(seed);
                add_write(t, 2 + 2 * q, r & 32'hffff_fffe);
                add_read(t, 1 + 2 * q);
                add_read(t, 2 + 2 * q);
            end
            add_write(t, 0, 32'hffff_ffff);
            add_read(t, 0);
            add_write(t, 0, 32'h0);
            add_read(t, 0);
        end
        add_read(2, 2 * QD + 1);   // unmapped offsets.
        add_read(1, 31);
        add_read(NT, 1);
        add_read(9, 0);
        add_round(1'b0);
        add_round(1'b1);
    endtask

    //======================================================================
    // bus tasks
    //======================================================================
    task automatic apb_access(input logic wr, input logic [`CFG_ADDR_WIDTH-1:0] a,
                              input logic [31:0] d, output logic [31:0] rdata,
                              output logic err);
        int cnt;
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        @(posedge clk);
        #2;
        penable = 1'b1;
        cnt     = 0;
        @(negedge clk);
        while (!pready) begin
            cnt++;
            if (cnt > APB_TIMEOUT) abort_run("APB transfer never got pready");
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic take_job(input logic random_ready, output logic [31:0] got);
        int          cnt;
        logic        accepted;
        logic [31:0] r;
        cnt      = 0;
        accepted = 1'b0;
        got      = '0;
        while (!accepted) begin
            @(posedge clk);
            #2;
            r         = $random(seed);
            job_ready = random_ready ? r[0] : 1'b1;
            @(negedge clk);
            if (job_valid && job_ready) begin
                accepted = 1'b1;
                got      = {2'b00, job_tile, job_addr, job_words};
            end
            cnt++;
            if (!accepted && cnt > JOB_TIMEOUT) abort_run("no store job offered in time");
        end
        @(posedge clk);
        #2;
        job_ready = 1'b0;
    endtask

    task automatic watch_no_job(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare_value("job_valid with no job due", {31'b0, job_valid}, 32'h0);
        end
    endtask

    //======================================================================
    // main sequence
    //======================================================================
    initial begin
        logic [31:0] rdata;
        logic        err;
        logic [31:0] got;
        seed      = 32'h608a_5648;
        clk       = 1'b0;
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        job_ready = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            case (tbl_kind[i])
                K_WR: begin
                    apb_access(1'b1, tbl_addr[i], tbl_data[i], rdata, err);
                    compare_value($sformatf("entry %0d write pslverr", i), {31'b0, err}, 0);
                end
                K_RD, K_RD_ERR: begin
                    apb_access(1'b0, tbl_addr[i], '0, rdata, err);
                    compare_value($sformatf("entry %0d read pslverr", i), {31'b0, err},
                                  {31'b0, tbl_kind[i] == K_RD_ERR});
                    compare_value($sformatf("entry %0d read data", i), rdata, tbl_exp[i]);
                end
                K_JOB: begin
                    take_job(tbl_data[i][0], got);
                    compare_value($sformatf("entry %0d job", i), got, tbl_exp[i]);
                end
                default: watch_no_job(int'(tbl_data[i]));
            endcase
        end
        if (u_glb_top.u_asserts.fail_cnt == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("bound assertions reported failures");
        end
    end

endmodule

`default_nettype wire

//--- tb/glb_asserts.sv
/*
 * Handshake assertions for the global buffer slice, bound into the top.
 * Checks APB pready framing, job port stability and the invalidate
 * pulse that follows each accepted job.
 */
`timescale 1ns/100ps
`default_nettype none

`include "glb_defs.svh"

module glb_asserts (
    input logic                                     clk,
    input logic                                     reset,
    input logic                                     psel,
    input logic                                     penable,
    input logic                                     pready,
    input logic                                     job_valid,
    input logic                                     job_ready,
    input logic [`TILE_ID_WIDTH-1:0]                job_tile,
    input logic [`GLB_ADDR_WIDTH-1:0]               job_addr,
    input logic [`MAX_NUM_WORDS_WIDTH-1:0]          job_words,
    input logic [`NUM_TILES*`QUEUE_DEPTH-1:0]       inval
);

    int unsigned fail_cnt = 0;   // read by the testbench.

    //======================================================================
    // apb side
    //======================================================================
    a_pready_framing: assert property (@(posedge clk) disable iff (reset)
        pready |-> (psel && penable))
        else begin
            fail_cnt++;
            $error("pready high outside an APB access phase");
        end

    //======================================================================
    // job port and invalidation
    //======================================================================
    a_job_stable: assert property (@(posedge clk) disable iff (reset)
        (job_valid && !job_ready) |=> (job_valid && $stable(job_tile)
                                       && $stable(job_addr) && $stable(job_words)))
        else begin
            fail_cnt++;
            $error("job dropped or changed while held back");
        end

    // exactly one pulse in the cycle after an accepted job, none otherwise.
    a_one_inval: assert property (@(posedge clk) disable iff (reset)
        $past(job_valid && job_ready) ? $onehot(inval) : (inval == '0))
        else begin
            fail_cnt++;
            $error("invalidate pulses do not match the accepted jobs");
        end

endmodule

`default_nettype wire

//--- src/glb_top.sv
/*
 * Global buffer configuration and store scheduling top level.
 * APB bridge, daisy-chained tile configuration blocks and scheduler.
 */
`timescale 1ns/100ps
`default_nettype none

`include "glb_defs.svh"

module glb_top (
    input  logic                            clk,
    input  logic                            reset,
    // apb slave.
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`CFG_ADDR_WIDTH-1:0]      paddr,
    input  logic [`CFG_DATA_WIDTH-1:0]      pwdata,
    output logic [`CFG_DATA_WIDTH-1:0]      prdata,
    output logic                            pready,
    output logic                            pslverr,
    // store job port.
    output logic                            job_valid,
    input  logic                            job_ready,
    output logic [`TILE_ID_WIDTH-1:0]       job_tile,
    output logic [`GLB_ADDR_WIDTH-1:0]      job_addr,
    output logic [`MAX_NUM_WORDS_WIDTH-1:0] job_words
);

    cfg_ifc     cfg_link [`NUM_TILES+1] ();   // link 0 is the bridge end.
    dma_hdr_ifc hdr_link [`NUM_TILES] ();

    glb_apb_bridge u_bridge (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg_link[0])
    );

    for (genvar t = 0; t < `NUM_TILES; t++) begin : g_tile
        glb_tile_cfg u_tile_cfg (
            .clk     (clk),
            .reset   (reset),
            .tile_id (`TILE_ID_WIDTH'(t)),
            .cfg_est (cfg_link[t]),
            .cfg_wst (cfg_link[t+1]),
            .hdr     (hdr_link[t])
        );
    end

    // nothing lies west of the last tile so unclaimed reads never return.
    assign cfg_link[`NUM_TILES].rd_data       = '0;
    assign cfg_link[`NUM_TILES].rd_data_valid = 1'b0;

    glb_store_sched u_sched (
        .clk       (clk),
        .reset     (reset),
        .job_ready (job_ready),
        .job_valid (job_valid),
        .job_tile  (job_tile),
        .job_addr  (job_addr),
        .job_words (job_words),
        .hdr       (hdr_link)
    );

endmodule

`default_nettype wire

//--- src/glb_store_sched.sv
/*
 * Round-robin store job scheduler.
 * Visits one tile per cycle, offers its lowest valid header as a job
 * and invalidates that header once the job is accepted.
 */
`timescale 1ns/100ps
`default_nettype none

`include "glb_defs.svh"

module glb_store_sched (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            job_ready,
    output logic                            job_valid,
    output logic [`TILE_ID_WIDTH-1:0]       job_tile,
    output logic [`GLB_ADDR_WIDTH-1:0]      job_addr,
    output logic [`MAX_NUM_WORDS_WIDTH-1:0] job_words,
    dma_hdr_ifc.sched                       hdr [`NUM_TILES]
);

    import glb_dma_pkg::*;

    function automatic logic [`TILE_ID_WIDTH-1:0] next_tile(
        input logic [`TILE_ID_WIDTH-1:0] t
    );
        return (t == `TILE_ID_WIDTH'(`NUM_TILES - 1)) ? '0 : t + 1'b1;
    endfunction

    sched_state_e                    state;
    logic [`TILE_ID_WIDTH-1:0]       ptr;          // round-robin pointer.
    dma_job_t                        job_q;
    logic [$clog2(`QUEUE_DEPTH)-1:0] job_idx;      // header behind the job.
    logic                            found;
    logic [$clog2(`QUEUE_DEPTH)-1:0] found_idx;
    logic [`NUM_TILES-1:0]           tile_on;
    dma_st_header_t                  tile_hdr [`NUM_TILES][`QUEUE_DEPTH];
    logic [`QUEUE_DEPTH-1:0]         inval    [`NUM_TILES];

    for (genvar t = 0; t < `NUM_TILES; t++) begin : g_link
        assign tile_on[t]                = hdr[t].dma_on;
        assign tile_hdr[t]               = hdr[t].headers;
        assign hdr[t].invalidate_pulse   = inval[t];
    end

    //======================================================================
    // header search in the current tile
    //======================================================================
    always_comb begin
        found     = 1'b0;
        found_idx = '0;
        for (int q = `QUEUE_DEPTH - 1; q >= 0; q--) begin   // lowest index wins.
            if (tile_hdr[ptr][q].valid) begin
                found     = 1'b1;
                found_idx = ($clog2(`QUEUE_DEPTH))'(q);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= SEARCH;
            ptr     <= '0;
            job_q   <= '0;
            job_idx <= '0;
        end else begin
            case (state)
                SEARCH: begin
                    if (tile_on[ptr] && found) begin
                        job_q.tile_id    <= ptr;
                        job_q.start_addr <= tile_hdr[ptr][found_idx].start_addr;
                        job_q.num_words  <= tile_hdr[ptr][found_idx].num_words;
                        job_idx          <= found_idx;
                        state            <= OFFER;
                    end else begin
                        ptr <= next_tile(ptr);
                    end
                end
                OFFER: if (job_ready) state <= CLEAR;
                CLEAR: begin
                    ptr   <= next_tile(ptr);
                    state <= SEARCH;
                end
                default: state <= SEARCH;
            endcase
        end
    end

    always_comb begin
        for (int t = 0; t < `NUM_TILES; t++) begin
            inval[t] = '0;
        end
        if (state == CLEAR) inval[job_q.tile_id][job_idx] = 1'b1;
    end

    assign job_valid = (state == OFFER);
    assign job_tile  = job_q.tile_id;
    assign job_addr  = job_q.start_addr;
    assign job_words = job_q.num_words;

endmodule

`default_nettype wire

//--- src/glb_tile_cfg.sv
/*
 * Tile configuration block with its chain router stage.
 * Holds dma_on and the store header queue, and forwards accesses
 * for other tiles west while returning read data east.
 */
`timescale 1ns/100ps
`default_nettype none

`include "glb_defs.svh"

module glb_tile_cfg (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`TILE_ID_WIDTH-1:0] tile_id,
    cfg_ifc.slave                     cfg_est,
    cfg_ifc.master                    cfg_wst,
    dma_hdr_ifc.tile                  hdr
);

    import glb_cfg_pkg::*;

    // header entries alternate between the words and the addr register.
    function automatic cfg_reg_e reg_kind(input logic [`CFG_REG_WIDTH-1:0] off);
        logic [`CFG_REG_WIDTH-1:0] rel;
        rel = off - 1'b1;
        if (off == REG_CTRL) return REG_CTRL;
        return rel[0] ? REG_HDR_ADDR : REG_HDR_WORDS;
    endfunction

    function automatic logic [$clog2(`QUEUE_DEPTH)-1:0] reg_queue(
        input logic [`CFG_REG_WIDTH-1:0] off
    );
        logic [`CFG_REG_WIDTH-1:0] rel;
        rel = off - 1'b1;
        return rel[1 +: $clog2(`QUEUE_DEPTH)];
    endfunction

    logic [`CFG_REG_WIDTH-1:0]       wr_off, rd_off;
    logic                            wr_claim, rd_claim;
    logic                            wr_mapped, rd_mapped;
    cfg_reg_e                        wr_kind, rd_kind;
    logic [$clog2(`QUEUE_DEPTH)-1:0] wr_q, rd_q;
    logic [`CFG_DATA_WIDTH-1:0]      rd_data_int;

    //======================================================================
    // address decode
    //======================================================================
    assign wr_off    = cfg_est.wr_addr[`CFG_REG_LSB +: `CFG_REG_WIDTH];
    assign rd_off    = cfg_est.rd_addr[`CFG_REG_LSB +: `CFG_REG_WIDTH];
    assign wr_claim  = cfg_est.wr_en
                    && (cfg_est.wr_addr[`CFG_TILE_LSB +: `CFG_TILE_WIDTH]
                        == `CFG_TILE_WIDTH'(tile_id));
    assign rd_claim  = cfg_est.rd_en
                    && (cfg_est.rd_addr[`CFG_TILE_LSB +: `CFG_TILE_WIDTH]
                        == `CFG_TILE_WIDTH'(tile_id));
    assign wr_mapped = wr_off <= `CFG_REG_WIDTH'(2 * `QUEUE_DEPTH);
    assign rd_mapped = rd_off <= `CFG_REG_WIDTH'(2 * `QUEUE_DEPTH);
    assign wr_kind   = reg_kind(wr_off);
    assign rd_kind   = reg_kind(rd_off);
    assign wr_q      = reg_queue(wr_off);
    assign rd_q      = reg_queue(rd_off);

    //======================================================================
    // registers
    //======================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hdr.dma_on <= 1'b0;
            for (int q = 0; q < `QUEUE_DEPTH; q++) begin
                hdr.headers[q] <= '0;
            end
        end else begin
            for (int q = 0; q < `QUEUE_DEPTH; q++) begin
                if (hdr.invalidate_pulse[q]) hdr.headers[q].valid <= 1'b0;
            end
            // a write in the same cycle overrides the invalidate.
            if (wr_claim && wr_mapped) begin
                case (wr_kind)
                    REG_CTRL:      hdr.dma_on <= cfg_est.wr_data[0];
                    REG_HDR_WORDS: hdr.headers[wr_q].num_words <=
                                       cfg_est.wr_data[`MAX_NUM_WORDS_WIDTH-1:0];
                    REG_HDR_ADDR:  {hdr.headers[wr_q].start_addr, hdr.headers[wr_q].valid} <=
                                       cfg_est.wr_data[`GLB_ADDR_WIDTH:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rd_data_int = '0;   // unmapped offsets read zero.
        if (rd_mapped) begin
            case (rd_kind)
                REG_CTRL:      rd_data_int = `CFG_DATA_WIDTH'(hdr.dma_on);
                REG_HDR_WORDS: rd_data_int = `CFG_DATA_WIDTH'(hdr.headers[rd_q].num_words);
                REG_HDR_ADDR:  rd_data_int = `CFG_DATA_WIDTH'({hdr.headers[rd_q].start_addr,
                                                               hdr.headers[rd_q].valid});
                default:       rd_data_int = '0;
            endcase
        end
    end

    //======================================================================
    // router stage
    //======================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_wst.wr_en         <= 1'b0;
            cfg_wst.wr_addr       <= '0;
            cfg_wst.wr_data       <= '0;
            cfg_wst.rd_en         <= 1'b0;
            cfg_wst.rd_addr       <= '0;
            cfg_est.rd_data       <= '0;
            cfg_est.rd_data_valid <= 1'b0;
        end else begin
            cfg_wst.wr_en   <= cfg_est.wr_en && !wr_claim;   // unclaimed goes west.
            cfg_wst.wr_addr <= cfg_est.wr_addr;
            cfg_wst.wr_data <= cfg_est.wr_data;
            cfg_wst.rd_en   <= cfg_est.rd_en && !rd_claim;
            cfg_wst.rd_addr <= cfg_est.rd_addr;
            if (rd_claim) begin
                cfg_est.rd_data       <= rd_data_int;
                cfg_est.rd_data_valid <= 1'b1;
            end else begin
                cfg_est.rd_data       <= cfg_wst.rd_data;   // registered west return.
                cfg_est.rd_data_valid <= cfg_wst.rd_data_valid;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/glb_apb_bridge.sv
/*
 * APB slave bridge to the configuration chain.
 * Launches one chain strobe per transfer and waits for read return,
 * with a timeout that ends the transfer with pslverr.
 */
`timescale 1ns/100ps
`default_nettype none

`include "glb_defs.svh"

module glb_apb_bridge (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`CFG_ADDR_WIDTH-1:0] paddr,
    input  logic [`CFG_DATA_WIDTH-1:0] pwdata,
    output logic [`CFG_DATA_WIDTH-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    cfg_ifc.master                     cfg
);

    import glb_cfg_pkg::*;

    bridge_state_e                       state;
    logic [$clog2(`CFG_RD_TIMEOUT)-1:0] wait_cnt;
    logic                                setup;

    assign setup  = psel && !penable;
    assign pready = (state == WRITE) || (state == DONE);

    //======================================================================
    // transfer fsm
    //======================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            wait_cnt    <= '0;
            prdata      <= '0;
            pslverr     <= 1'b0;
            cfg.wr_en   <= 1'b0;
            cfg.wr_addr <= '0;
            cfg.wr_data <= '0;
            cfg.rd_en   <= 1'b0;
            cfg.rd_addr <= '0;
        end else begin
            cfg.wr_en <= 1'b0;   // strobes last one cycle.
            cfg.rd_en <= 1'b0;
            case (state)
                IDLE: begin
                    if (setup && pwrite) begin
                        cfg.wr_en   <= 1'b1;
                        cfg.wr_addr <= paddr;
                        cfg.wr_data <= pwdata;
                        state       <= WRITE;
                    end else if (setup) begin
                        cfg.rd_en   <= 1'b1;
                        cfg.rd_addr <= paddr;
                        wait_cnt    <= '0;
                        state       <= READ_WAIT;
                    end
                end
                WRITE: state <= IDLE;   // pready is high this cycle.
                READ_WAIT: begin
                    if (cfg.rd_data_valid) begin
                        prdata <= cfg.rd_data;
                        state  <= DONE;
                    end else if (wait_cnt == ($clog2(`CFG_RD_TIMEOUT))'(`CFG_RD_TIMEOUT - 1)) begin
                        prdata  <= '0;   // no tile claimed the read.
                        pslverr <= 1'b1;
                        state   <= DONE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                DONE: begin
                    pslverr <= 1'b0;
                    state   <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/dma_hdr_ifc.sv
/*
 * Store header link between one tile and the scheduler.
 */
`timescale 1ns/100ps
`default_nettype none

`include "glb_defs.svh"

interface dma_hdr_ifc;

    import glb_dma_pkg::*;

    dma_st_header_t          headers [`QUEUE_DEPTH];
    logic                    dma_on;
    logic [`QUEUE_DEPTH-1:0] invalidate_pulse;   // one bit per header.

    modport tile  (output headers, dma_on, input  invalidate_pulse);
    modport sched (input  headers, dma_on, output invalidate_pulse);

endinterface

`default_nettype wire

//--- src/cfg_ifc.sv
/*
 * Configuration chain link.
 * Write and read strobes travel west, read return travels east.
 */
`timescale 1ns/100ps
`default_nettype none

`include "glb_defs.svh"

interface cfg_ifc;

    logic                       wr_en;
    logic [`CFG_ADDR_WIDTH-1:0] wr_addr;
    logic [`CFG_DATA_WIDTH-1:0] wr_data;
    logic                       rd_en;
    logic [`CFG_ADDR_WIDTH-1:0] rd_addr;
    logic [`CFG_DATA_WIDTH-1:0] rd_data;
    logic                       rd_data_valid;

    modport master (
        output wr_en, wr_addr, wr_data, rd_en, rd_addr,
        input  rd_data, rd_data_valid
    );

    modport slave (
        input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
        output rd_data, rd_data_valid
    );

endinterface

`default_nettype wire

//--- src/glb_dma_pkg.sv
/*
 * Store DMA types of the global buffer.
 * Header queue entry, scheduled job and scheduler states.
 */
`default_nettype none

`include "glb_defs.svh"

package glb_dma_pkg;

    typedef struct packed {
        logic                            valid;
        logic [`GLB_ADDR_WIDTH-1:0]      start_addr;
        logic [`MAX_NUM_WORDS_WIDTH-1:0] num_words;
    } dma_st_header_t;

    typedef struct packed {
        logic [`TILE_ID_WIDTH-1:0]       tile_id;
        logic [`GLB_ADDR_WIDTH-1:0]      start_addr;
        logic [`MAX_NUM_WORDS_WIDTH-1:0] num_words;
    } dma_job_t;

    typedef enum logic [1:0] {
        SEARCH,   // one tile per cycle.
        OFFER,    // job_valid held until accepted.
        CLEAR     // invalidate pulse to the owning tile.
    } sched_state_e;

endpackage

`default_nettype wire

//--- src/glb_cfg_pkg.sv
/*
 * Configuration-side types of the global buffer.
 * Register offsets inside a tile and the APB bridge states.
 */
`default_nettype none

`include "glb_defs.svh"

package glb_cfg_pkg;

    // queue entry q sits at REG_HDR_WORDS + 2q and REG_HDR_ADDR + 2q.
    typedef enum logic [`CFG_REG_WIDTH-1:0] {
        REG_CTRL      = 'd0,   // bit 0 is dma_on.
        REG_HDR_WORDS = 'd1,   // num_words.
        REG_HDR_ADDR  = 'd2    // {start_addr, valid}.
    } cfg_reg_e;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ_WAIT,
        DONE
    } bridge_state_e;

endpackage

`default_nettype wire

//--- src/glb_defs.svh
/*
 * Shared sizes and address fields of the global buffer configuration slice.
 * Tile count, queue depth, bus widths and the bridge read timeout.
 */
`ifndef GLB_DEFS_SVH
`define GLB_DEFS_SVH

// tiling and store queue.
`define NUM_TILES           4
`define TILE_ID_WIDTH       2
`define QUEUE_DEPTH         4

// dma header fields.
`define GLB_ADDR_WIDTH      16
`define MAX_NUM_WORDS_WIDTH 12

// configuration bus.
`define CFG_ADDR_WIDTH      12
`define CFG_DATA_WIDTH      32

// tile field in bits 10..7 and register field in bits 6..2.
`define CFG_TILE_LSB        7
`define CFG_TILE_WIDTH      4
`define CFG_REG_LSB         2
`define CFG_REG_WIDTH       5

`define CFG_RD_TIMEOUT      32   // cycles before an unclaimed read errors out.

`endif
